// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_saturn_bus
FILELIST   := compile.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
BUILD_DIR  := obj_dir
RUN_ARGS   := +verilator+error+limit+1000
LOG        := sim.log
PASS_TEXT  := TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
hw/saturn_bus_pkg.sv
hw/bus_phase_timer.sv
hw/bus_sequencer.sv
hw/addr_serializer.sv
hw/read_capture.sv
hw/saturn_bus_ctrl.sv
test/saturn_bus_checker.sv
test/tb_saturn_bus.sv

// ==== hw/addr_serializer.sv ====
// ==========================================================
// address serializer
// holds command code and address, picks the bus nibble
// ==========================================================

`timescale 1ns/1ns

module addr_serializer
  import saturn_bus_pkg::*;
(
  input  logic    i_clk,
  input  logic    cmd_RESET_0,
  input  logic    i_load,
  input  logic    i_advance,
  input  logic    i_send_addr,
  input  buscmd_t i_cmd,
  input  addr_t   i_addr,
  output nibble_t o_bus_data,
  output logic    o_addr_last
);

  localparam int idx_w = $clog2(addr_nibbles);

  buscmd_t          cmd_q;
  addr_t            addr_q;
  // which address nibble is on the bus, lsn first
  logic [idx_w-1:0] nib_idx;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      cmd_q   <= buscmd_nop;
      nib_idx <= '0;
    end else if (i_load) begin
      cmd_q   <= i_cmd;
      nib_idx <= '0;
    end else if (i_advance && !o_addr_last) begin
      nib_idx <= nib_idx + 1'b1;
    end
  end

  // address is payload only
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      addr_q <= i_addr;
    end
  end

  assign o_addr_last = (nib_idx == idx_w'(addr_nibbles - 1));

  // command code unless inside the address run
  assign o_bus_data = i_send_addr ? addr_q[nibble_w*nib_idx +: nibble_w] : nibble_t'(cmd_q);

endmodule

// ==== hw/bus_phase_timer.sv ====
// ==========================================================
// bus phase timer
// free-running four-phase count pacing every bus cycle
// ==========================================================

`timescale 1ns/1ns

module bus_phase_timer
  import saturn_bus_pkg::*;
(
  input  logic   i_clk,
  input  logic   cmd_RESET_0,
  output phase_t o_phase
);

  // current phase, ph_0 in the first clock after reset
  phase_t phase_q;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      phase_q <= ph_0;
    end else begin
      // wraps from ph_3 back to ph_0
      phase_q <= phase_t'(phase_q + 2'd1);
    end
  end

  // all other blocks time their actions from this
  assign o_phase = phase_q;

endmodule

// ==== hw/bus_sequencer.sv ====
// ==========================================================
// bus sequencer
// picks each bus cycle, drives strobe, cmd/data, bus reset
// ==========================================================

`timescale 1ns/1ns

module bus_sequencer
  import saturn_bus_pkg::*;
(
  input  logic    i_clk,
  input  logic    cmd_RESET_0,
  input  phase_t  i_phase,
  input  logic    i_req_valid,
  input  req_op_t i_req_op,
  input  logic    i_addr_last,
  input  logic    i_rd_pending,
  output logic    o_req_ready,
  output logic    o_bus_reset,
  output logic    o_bus_strobe,
  output logic    o_bus_cmd_data,
  output logic    o_load,
  output logic    o_advance,
  output logic    o_send_addr,
  output logic    o_sample,
  output buscmd_t o_cmd
);

  typedef enum logic [2:0] {
    st_startup,
    st_idle,
    st_cmd,
    st_addr,
    st_rd_cmd,
    st_rd_data
  } state_t;

  state_t  state;
  // last command code that went out on the bus
  buscmd_t last_cmd;
  // set once a full round has passed with bus reset high
  logic    startup_armed;
  logic    strobe_q;
  logic    cmd_data_q;
  logic    bus_reset_q;
  logic    req_fire;
  // device already in pc read mode, no PC_READ command needed
  logic    pc_read_mode;

  // accept only at ph_0 from idle, never over a pending read
  assign o_req_ready  = (state == st_idle) && (i_phase == ph_0) && !i_rd_pending;
  assign req_fire     = o_req_ready && i_req_valid;
  assign pc_read_mode = (last_cmd == buscmd_load_pc) || (last_cmd == buscmd_pc_read);

  // command code handed to the serializer at acceptance
  assign o_cmd  = (i_req_op == op_load_pc) ? buscmd_load_pc : buscmd_pc_read;
  assign o_load = req_fire && ((i_req_op == op_load_pc) || !pc_read_mode);

  // next address nibble at each later ph_0 of the address run
  assign o_advance   = (state == st_addr) && (i_phase == ph_0);
  assign o_send_addr = (state == st_addr);

  // strobe only high in ph_1, so this is the data strobe clock
  assign o_sample = (state == st_rd_data) && strobe_q;

  assign o_bus_strobe   = strobe_q;
  assign o_bus_cmd_data = cmd_data_q;
  assign o_bus_reset    = bus_reset_q;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      state         <= st_startup;
      last_cmd      <= buscmd_nop;
      startup_armed <= 1'b0;
      strobe_q      <= 1'b0;
      cmd_data_q    <= 1'b1;
      bus_reset_q   <= 1'b1;
    end else begin
      // strobe drops at end of ph_1, cmd/data back to data level
      if (i_phase == ph_1) begin
        strobe_q   <= 1'b0;
        cmd_data_q <= 1'b1;
      end
      case (state)
        // one quiet round, then a single strobe with bus reset high
        st_startup: begin
          if ((i_phase == ph_0) && startup_armed) begin
            strobe_q <= 1'b1;
          end
          if (i_phase == ph_3) begin
            startup_armed <= 1'b1;
            if (startup_armed) begin
              bus_reset_q <= 1'b0;
              state       <= st_idle;
            end
          end
        end
        st_idle: begin
          if (req_fire) begin
            strobe_q <= 1'b1;
            if (i_req_op == op_load_pc) begin
              cmd_data_q <= 1'b0;
              last_cmd   <= buscmd_load_pc;
              state      <= st_cmd;
            end else if (pc_read_mode) begin
              // straight to the data cycle
              state <= st_rd_data;
            end else begin
              cmd_data_q <= 1'b0;
              last_cmd   <= buscmd_pc_read;
              state      <= st_rd_cmd;
            end
          end
        end
        // LOAD_PC command sent, first address nibble next
        st_cmd: begin
          if (i_phase == ph_0) begin
            strobe_q <= 1'b1;
            state    <= st_addr;
          end
        end
        st_addr: begin
          if (i_phase == ph_0) begin
            strobe_q <= 1'b1;
          end else if ((i_phase == ph_3) && i_addr_last) begin
            // device now in pc read mode on its own
            state <= st_idle;
          end
        end
        st_rd_cmd: begin
          if (i_phase == ph_0) begin
            strobe_q <= 1'b1;
            state    <= st_rd_data;
          end
        end
        st_rd_data: begin
          if (i_phase == ph_3) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// ==== hw/read_capture.sv ====
// ==========================================================
// read capture
// samples the bus nibble, holds it on valid/ready
// ==========================================================

`timescale 1ns/1ns

module read_capture
  import saturn_bus_pkg::*;
(
  input  logic    i_clk,
  input  logic    cmd_RESET_0,
  input  logic    i_sample,
  input  logic    i_rd_ready,
  input  nibble_t i_bus_data,
  output logic    o_rd_valid,
  output nibble_t o_rd_nibble
);

  logic    valid_q;
  nibble_t nibble_q;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      valid_q <= 1'b0;
    end else if (i_sample) begin
      valid_q <= 1'b1;
    end else if (i_rd_ready) begin
      // core took it
      valid_q <= 1'b0;
    end
  end

  // nibble frozen until the next sample
  always_ff @(posedge i_clk) begin
    if (i_sample) begin
      nibble_q <= i_bus_data;
    end
  end

  assign o_rd_valid  = valid_q;
  assign o_rd_nibble = nibble_q;

endmodule

// ==== hw/saturn_bus_ctrl.sv ====
// ==========================================================
// saturn nibble bus controller
// turns core requests into four-phase bus cycles
// ==========================================================

`timescale 1ns/1ns

module saturn_bus_ctrl
  import saturn_bus_pkg::*;
(
  input  logic    i_clk,
  input  logic    cmd_RESET_0,
  input  logic    i_req_valid,
  input  req_op_t i_req_op,
  input  addr_t   i_req_addr,
  output logic    o_req_ready,
  output logic    o_rd_valid,
  output nibble_t o_rd_nibble,
  input  logic    i_rd_ready,
  output logic    o_bus_reset,
  output logic    o_bus_strobe,
  output logic    o_bus_cmd_data,
  output nibble_t o_bus_data,
  input  nibble_t i_bus_data
);

  phase_t  phase;
  buscmd_t cmd;
  logic    load;
  logic    advance;
  logic    send_addr;
  logic    addr_last;
  logic    sample;

  bus_phase_timer u_phase_timer (
    .i_clk       (i_clk),
    .cmd_RESET_0 (cmd_RESET_0),
    .o_phase     (phase)
  );

  // read valid fed back so no new cycle starts over a pending nibble
  bus_sequencer u_sequencer (
    .i_clk          (i_clk),
    .cmd_RESET_0    (cmd_RESET_0),
    .i_phase        (phase),
    .i_req_valid    (i_req_valid),
    .i_req_op       (i_req_op),
    .i_addr_last    (addr_last),
    .i_rd_pending   (o_rd_valid),
    .o_req_ready    (o_req_ready),
    .o_bus_reset    (o_bus_reset),
    .o_bus_strobe   (o_bus_strobe),
    .o_bus_cmd_data (o_bus_cmd_data),
    .o_load         (load),
    .o_advance      (advance),
    .o_send_addr    (send_addr),
    .o_sample       (sample),
    .o_cmd          (cmd)
  );

  addr_serializer u_addr_serializer (
    .i_clk       (i_clk),
    .cmd_RESET_0 (cmd_RESET_0),
    .i_load      (load),
    .i_advance   (advance),
    .i_send_addr (send_addr),
    .i_cmd       (cmd),
    .i_addr      (i_req_addr),
    .o_bus_data  (o_bus_data),
    .o_addr_last (addr_last)
  );

  read_capture u_read_capture (
    .i_clk       (i_clk),
    .cmd_RESET_0 (cmd_RESET_0),
    .i_sample    (sample),
    .i_rd_ready  (i_rd_ready),
    .i_bus_data  (i_bus_data),
    .o_rd_valid  (o_rd_valid),
    .o_rd_nibble (o_rd_nibble)
  );

endmodule

// ==== hw/saturn_bus_pkg.sv ====
// ==========================================================
// saturn nibble bus shared definitions
// command codes, widths, bus phase and request kinds
// ==========================================================

package saturn_bus_pkg;

  // width of one bus nibble
  localparam int nibble_w = 4;

  // full address width
  localparam int addr_w = 20;

  // nibbles sent after a LOAD_PC command
  localparam int addr_nibbles = 5;

  typedef logic [nibble_w-1:0] nibble_t;
  typedef logic [addr_w-1:0] addr_t;

  // one bus cycle is four phases, strobe lives in ph_1
  typedef enum logic [1:0] {
    ph_0 = 2'd0,
    ph_1 = 2'd1,
    ph_2 = 2'd2,
    ph_3 = 2'd3
  } phase_t;

  // command codes put on the data lines with cmd/data low
  typedef enum logic [3:0] {
    buscmd_pc_read = 4'h0,
    buscmd_load_pc = 4'h4,
    buscmd_nop     = 4'hf
  } buscmd_t;

  // request kinds from the core
  typedef enum logic {
    op_load_pc = 1'b0,
    op_read    = 1'b1
  } req_op_t;

endpackage

// ==== test/saturn_bus_checker.sv ====
// ==========================================================
// saturn bus protocol checker
// concurrent assertions on strobe, start-up and read hold
// ==========================================================

`timescale 1ns/1ns

module saturn_bus_checker
  import saturn_bus_pkg::*;
(
  input logic    i_clk,
  input logic    cmd_RESET_0,
  input logic    i_req_ready,
  input logic    i_rd_valid,
  input logic    i_rd_ready,
  input nibble_t i_rd_nibble,
  input logic    i_bus_reset,
  input logic    i_bus_strobe
);

  // failures seen so far, read by the testbench at the end
  int         fail_count = 0;
  logic       seen_strobe;
  // strobes issued while bus reset was high
  logic [1:0] reset_strobes;
  // clocks since the last strobe
  int         since_strobe;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_0) begin
      seen_strobe   <= 1'b0;
      reset_strobes <= '0;
      since_strobe  <= 0;
    end else if (i_bus_strobe) begin
      seen_strobe  <= 1'b1;
      since_strobe <= 1;
      if (i_bus_reset) begin
        reset_strobes <= reset_strobes + 2'd1;
      end
    end else begin
      since_strobe <= since_strobe + 1;
    end
  end

  // bus reset held until the start-up strobe
  a_reset_until_strobe: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    !seen_strobe |-> i_bus_reset)
    else begin
      $error("bus reset dropped before the start-up strobe");
      fail_count++;
    end

  // no request and no read while the bus is still in reset
  a_quiet_startup: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    i_bus_reset |-> (!i_req_ready && !i_rd_valid))
    else begin
      $error("request or read active during bus start-up");
      fail_count++;
    end

  a_one_reset_strobe: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    (i_bus_strobe && i_bus_reset) |-> (reset_strobes == 2'd0))
    else begin
      $error("more than one strobe with bus reset high");
      fail_count++;
    end

  a_reset_release: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    $fell(i_bus_reset) |-> (reset_strobes == 2'd1))
    else begin
      $error("bus reset released without exactly one strobe");
      fail_count++;
    end

  // strobe is a single clock
  a_strobe_single: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    i_bus_strobe |=> !i_bus_strobe)
    else begin
      $error("strobe high on two consecutive clocks");
      fail_count++;
    end

  // whole bus cycles between strobes
  a_strobe_spacing: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    (i_bus_strobe && seen_strobe) |-> ((since_strobe % 4) == 0))
    else begin
      $error("strobes not a multiple of four clocks apart");
      fail_count++;
    end

  a_hold_nibble: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    (i_rd_valid && !i_rd_ready) |=> (i_rd_valid && $stable(i_rd_nibble)))
    else begin
      $error("read nibble changed or dropped while stalled");
      fail_count++;
    end

  // stalled read freezes the whole bus
  a_stall_blocks_bus: assert property (@(posedge i_clk) disable iff (cmd_RESET_0)
    (i_rd_valid && !i_rd_ready) |-> (!i_req_ready && !i_bus_strobe))
    else begin
      $error("request accepted or strobe issued over a stalled read");
      fail_count++;
    end

endmodule

bind saturn_bus_ctrl saturn_bus_checker u_checker (
  .i_clk        (i_clk),
  .cmd_RESET_0  (cmd_RESET_0),
  .i_req_ready  (o_req_ready),
  .i_rd_valid   (o_rd_valid),
  .i_rd_ready   (i_rd_ready),
  .i_rd_nibble  (o_rd_nibble),
  .i_bus_reset  (o_bus_reset),
  .i_bus_strobe (o_bus_strobe)
);

// ==== test/tb_saturn_bus.sv ====
// ==========================================================
// saturn bus controller testbench
// nibble bus device model, request stimulus, read checks
// ==========================================================

`timescale 1ns/1ns

module tb_saturn_bus
  import saturn_bus_pkg::*;
();

  localparam int clk_period    = 40;
  localparam int n_first_reads = 2;
  localparam int n_loads       = 4;
  localparam int max_reads     = 4;
  // reads after start-up and each load with up to max_reads reads
  localparam int n_requests    = n_first_reads + n_loads * (1 + max_reads);
  localparam int limit_ns      = (n_requests * 12 + 200) * clk_period;

  logic    i_clk = 1'b0;
  logic    cmd_RESET_0;
  logic    i_req_valid;
  req_op_t i_req_op;
  addr_t   i_req_addr;
  logic    i_rd_ready;
  nibble_t i_bus_data = '0;
  logic    o_req_ready;
  logic    o_rd_valid;
  nibble_t o_rd_nibble;
  logic    o_bus_reset;
  logic    o_bus_strobe;
  logic    o_bus_cmd_data;
  nibble_t o_bus_data;

  integer  seed = 32'hbf699a34;
  // device memory indexed by the low pc nibble
  nibble_t mem [16];

  // device model state
  buscmd_t dev_cmd;
  int      dev_cnt;
  addr_t   dev_pc;
  int      cmd_done;
  int      bus_errors = 0;

  // what the stimulus expects on the bus
  int      cmd_due;
  buscmd_t want_code;
  addr_t   want_addr;
  addr_t   exp_pc;
  logic    pc_mode;
  int      stim_errors;

  always #(clk_period / 2) i_clk = ~i_clk;

  saturn_bus_ctrl u_dut (
    .i_clk          (i_clk),
    .cmd_RESET_0    (cmd_RESET_0),
    .i_req_valid    (i_req_valid),
    .i_req_op       (i_req_op),
    .i_req_addr     (i_req_addr),
    .o_req_ready    (o_req_ready),
    .o_rd_valid     (o_rd_valid),
    .o_rd_nibble    (o_rd_nibble),
    .i_rd_ready     (i_rd_ready),
    .o_bus_reset    (o_bus_reset),
    .o_bus_strobe   (o_bus_strobe),
    .o_bus_cmd_data (o_bus_cmd_data),
    .o_bus_data     (o_bus_data),
    .i_bus_data     (i_bus_data)
  );

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  // device reacts on every strobe
  always @(posedge i_clk) begin
    if (cmd_RESET_0 || (o_bus_strobe && o_bus_reset)) begin
      dev_cmd  = buscmd_nop;
      dev_cnt  = 0;
      dev_pc   = '0;
      cmd_done = 0;
    end else if (o_bus_strobe) begin
      if (!o_bus_cmd_data) begin
        assert (cmd_done < cmd_due) else begin
          bus_errors++;
          $display("device fault at %0t ns: command strobe with no request due", $time);
        end
        assert (o_bus_data == want_code) else begin
          bus_errors++;
          show_mismatch("o_bus_data", 32'(o_bus_data), 32'(want_code));
        end
        cmd_done++;
        dev_cmd = buscmd_t'(o_bus_data);
        dev_cnt = 0;
      end else if ((dev_cmd == buscmd_load_pc) && (dev_cnt < addr_nibbles)) begin
        // address nibbles arrive lsn first
        assert (o_bus_data == want_addr[nibble_w*dev_cnt +: nibble_w]) else begin
          bus_errors++;
          show_mismatch("o_bus_data", 32'(o_bus_data),
                        32'(want_addr[nibble_w*dev_cnt +: nibble_w]));
        end
        dev_pc[nibble_w*dev_cnt +: nibble_w] = o_bus_data;
        dev_cnt++;
      end else if ((dev_cmd == buscmd_load_pc) || (dev_cmd == buscmd_pc_read)) begin
        // data cycle with the nibble already on i_bus_data
        assert (cmd_done == cmd_due) else begin
          bus_errors++;
          $display("device fault at %0t ns: data read without a PC_READ command", $time);
        end
        dev_pc = dev_pc + 1'b1;
      end else begin
        bus_errors++;
        $display("device fault at %0t ns: data strobe with the device in no read mode",
                 $time);
      end
    end
    i_bus_data <= mem[dev_pc[3:0]];
  end

  task automatic issue_request(input req_op_t op, input addr_t addr);
    i_req_valid <= 1'b1;
    i_req_op    <= op;
    i_req_addr  <= addr;
    @(posedge i_clk);
    while (!o_req_ready) @(posedge i_clk);
    i_req_valid <= 1'b0;
    // command strobe due only for load or for a read outside pc mode
    if (op == op_load_pc) begin
      cmd_due++;
      want_code = buscmd_load_pc;
      want_addr = addr;
      exp_pc    = addr;
    end else if (!pc_mode) begin
      cmd_due++;
      want_code = buscmd_pc_read;
    end
    pc_mode = 1'b1;
  endtask

  task automatic take_read();
    int      stall;
    nibble_t expected;
    @(posedge i_clk);
    while (!o_rd_valid) @(posedge i_clk);
    stall = $unsigned($random(seed)) % 4;
    repeat (stall) @(posedge i_clk);
    i_rd_ready <= 1'b1;
    @(posedge i_clk);
    expected = mem[exp_pc[3:0]];
    assert (o_rd_nibble == expected) else begin
      stim_errors++;
      show_mismatch("o_rd_nibble", 32'(o_rd_nibble), 32'(expected));
    end
    exp_pc = exp_pc + 1'b1;
    i_rd_ready <= 1'b0;
  endtask

  initial begin
    addr_t addr;
    int    n_reads;
    cmd_RESET_0 = 1'b1;
    i_req_valid = 1'b0;
    i_req_op    = op_read;
    i_req_addr  = '0;
    i_rd_ready  = 1'b0;
    cmd_due     = 0;
    want_code   = buscmd_nop;
    want_addr   = '0;
    exp_pc      = '0;
    pc_mode     = 1'b0;
    stim_errors = 0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = nibble_t'($random(seed));
    end
    repeat (10) @(posedge i_clk);
    cmd_RESET_0 <= 1'b0;
    // no pc mode yet so PC_READ goes out before the first read only
    for (int r = 0; r < n_first_reads; r++) begin
      issue_request(op_read, '0);
      take_read();
    end
    for (int l = 0; l < n_loads; l++) begin
      addr = addr_t'($random(seed));
      issue_request(op_load_pc, addr);
      n_reads = 1 + ($unsigned($random(seed)) % max_reads);
      for (int r = 0; r < n_reads; r++) begin
        issue_request(op_read, '0);
        take_read();
      end
    end
    repeat (8) @(posedge i_clk);
    assert (dev_pc == exp_pc) else begin
      stim_errors++;
      show_mismatch("device pc", 32'(dev_pc), 32'(exp_pc));
    end
    assert (cmd_done == cmd_due) else begin
      stim_errors++;
      $display("device saw %0d command strobes where %0d were due", cmd_done, cmd_due);
    end
    $display("checks done: %0d stimulus errors, %0d bus model errors, %0d assertion failures",
             stim_errors, bus_errors, u_dut.u_checker.fail_count);
    if ((stim_errors + bus_errors + u_dut.u_checker.fail_count) == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog sized from the request count
  initial begin
    #(limit_ns);
    $display("watchdog expired after %0d ns, controller stopped answering", limit_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
